//--- rtl/memPkg.sv
package memPkg;

    // ===================================================================
    // Widths
    // ===================================================================
    typedef logic [31:0]  word_t;
    typedef logic [29:0]  wordAddr_t;
    typedef logic [3:0]   byteMask_t;
    typedef logic [9:0]   sramAddr_t;
    typedef logic [9:0]   progress_t;
    typedef logic [127:0] instrLine_t;
    typedef logic [27:0]  instrAddr_t;
    typedef logic [63:0]  icEntry_t;    // Two instruction words, odd word on top.
    typedef logic [8:0]   icIndex_t;

    localparam int burstLen    = 16;
    localparam int dcacheWords = 1024;
    localparam int icacheDepth = 512;
    localparam wordAddr_t consoleAddr = 30'h3F800000;

    // ===================================================================
    // Port and command bundles
    // ===================================================================
    typedef struct packed {
        logic      ce;
        logic      we;
        byteMask_t wm;
        wordAddr_t addr;
        word_t     data;
    } cachePort_t;

    typedef struct packed {
        logic      ce;
        logic      we;          // Set for a store to external memory.
        logic      cacheId;     // Zero selects the data cache.
        sramAddr_t sramAddr;
        wordAddr_t extAddr;
    } mcCmd_t;

    typedef struct packed {
        logic       ce;
        logic       we;
        logic [7:0] wm;
        icIndex_t   addr;
        icEntry_t   data;
    } icPort_t;

    typedef enum logic [1:0] {
        idle,
        command,
        transfer,
        drain
    } mcState_t;

endpackage

//--- rtl/cacheSram.sv
`timescale 1ns/10ps

module cacheSram #(
    parameter int dataWidth = 32,
    parameter int depth     = 1024
) (
    input  logic                         clk,
    input  logic                         ce,
    input  logic                         we,
    input  logic [dataWidth/8-1:0]       wm,
    input  logic [$clog2(depth)-1:0]     addr,
    input  logic [dataWidth-1:0]         data,
    output logic [dataWidth-1:0]         rdata,
    input  logic                         ce1,
    input  logic [$clog2(depth)-1:0]     addr1,
    output logic [dataWidth-1:0]         rdata1
);

    localparam int numBytes = dataWidth / 8;

    logic [dataWidth-1:0] mem [depth];

    // Port 0 either merges the enabled bytes or reads the whole word.
    always_ff @(posedge clk) begin
        if (ce) begin
            if (we) begin
                for (int i = 0; i < numBytes; i++) begin
                    if (wm[i]) begin
                        mem[addr][8*i +: 8] <= data[8*i +: 8];
                    end
                end
            end else begin
                rdata <= mem[addr];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ce1) begin
            rdata1 <= mem[addr1];   // Read-only port.
        end
    end

    // Matters when depth is not a power of two.
    assert property (@(posedge clk) ce |-> int'(addr) < depth)
        else $error("SRAM port 0 address out of range.");
    assert property (@(posedge clk) ce1 |-> int'(addr1) < depth)
        else $error("SRAM port 1 address out of range.");

endmodule

//--- rtl/memoryController.sv
`timescale 1ns/10ps

module memoryController (
    input  logic                      clk,
    input  logic                      reset,
    input  memPkg::mcCmd_t            cmd,
    output logic                      busy,
    output memPkg::progress_t         progress,
    output logic [1:0]                ctrlUsed,
    output memPkg::cachePort_t [1:0]  ctrlPort,
    input  memPkg::word_t             dcacheRdata,
    input  memPkg::word_t             icacheRdata,
    output logic                      extEn,
    output memPkg::word_t             extOut,
    input  memPkg::word_t             extIn
);
    import memPkg::*;

    mcState_t   state;
    mcCmd_t     cur;
    logic       accept;
    sramAddr_t  writeIdx;
    sramAddr_t  readIdx;
    word_t      cacheRdata;
    cachePort_t portReq;

    assign accept = cmd.ce && !busy;

    // ===================================================================
    // Burst sequencing
    // ===================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= idle;
            progress <= '0;
        end else begin
            unique case (state)
                idle: begin
                    if (accept) begin
                        state    <= command;
                        progress <= '0;
                    end
                end
                command: begin
                    state <= transfer;
                end
                transfer: begin
                    progress <= progress + 1'b1;
                    if (progress == progress_t'(burstLen - 2)) begin
                        state <= drain;    // Last word has no read-ahead.
                    end
                end
                drain: begin
                    progress <= progress + 1'b1;
                    state    <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur <= cmd;
        end
    end

    // ===================================================================
    // Cache and bus drive
    // ===================================================================
    always_comb begin
        writeIdx = cur.sramAddr + sramAddr_t'(progress);
        readIdx  = (state == command) ? cur.sramAddr : writeIdx + 1'b1;
        cacheRdata = cur.cacheId ? icacheRdata : dcacheRdata;
    end

    always_comb begin
        portReq = '0;
        unique case (state)
            command: begin
                portReq.ce   = cur.we;      // A store primes the first read.
                portReq.addr = wordAddr_t'(readIdx);
            end
            transfer: begin
                portReq.ce   = 1'b1;
                portReq.we   = !cur.we;
                portReq.wm   = '1;
                portReq.addr = wordAddr_t'(cur.we ? readIdx : writeIdx);
                portReq.data = extIn;
            end
            drain: begin
                portReq.ce   = !cur.we;
                portReq.we   = !cur.we;
                portReq.wm   = '1;
                portReq.addr = wordAddr_t'(writeIdx);
                portReq.data = extIn;
            end
            default: begin
                portReq = '0;
            end
        endcase
    end

    always_comb begin
        busy     = (state != idle);
        extEn    = busy;
        ctrlUsed = '0;
        if (busy) begin
            ctrlUsed[cur.cacheId] = 1'b1;
        end
        ctrlPort[0] = ctrlUsed[0] ? portReq : '0;
        ctrlPort[1] = ctrlUsed[1] ? portReq : '0;
        extOut = '0;
        if (state == command) begin
            extOut = {cur.we, 1'b0, cur.extAddr};
        end else if (busy && cur.we) begin
            extOut = cacheRdata;                // Word read in the previous cycle.
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(cmd.ce && busy))
        else $warning("Controller command dropped while busy.");
    assert property (@(posedge clk) disable iff (reset)
        accept |-> ##(burstLen + 2) (!busy && progress == progress_t'(burstLen)))
        else $error("Burst did not complete on schedule.");

endmodule

//--- rtl/cachePortRouter.sv
`timescale 1ns/10ps

module cachePortRouter (
    input  logic                      clk,
    input  logic [1:0]                ctrlUsed,
    input  memPkg::cachePort_t [1:0]  ctrlPort,
    input  memPkg::cachePort_t        corePort,
    input  logic                      coreReadEn,
    input  memPkg::wordAddr_t         coreReadAddr,
    input  logic                      fetchEn,
    input  memPkg::instrAddr_t        fetchAddr,
    output memPkg::cachePort_t        dcPort,
    output logic                      dcReadEn,
    output memPkg::sramAddr_t         dcReadAddr,
    output memPkg::icPort_t           icPort0,
    output memPkg::icPort_t           icPort1,
    output logic                      icLaneSel,
    output logic                      consoleValid,
    output logic [7:0]                consoleChar
);
    import memPkg::*;

    logic coreDcWrite;

    // ===================================================================
    // Data cache
    // ===================================================================
    always_comb begin
        coreDcWrite = corePort.ce && corePort.we && (corePort.addr < dcacheWords);
        if (ctrlUsed[0]) begin
            dcPort = ctrlPort[0];
        end else begin
            dcPort    = corePort;
            dcPort.ce = corePort.ce && (corePort.addr < dcacheWords);
        end
        dcReadEn   = coreReadEn && (coreReadAddr < dcacheWords);
        dcReadAddr = coreReadAddr[9:0];
    end

    // ===================================================================
    // Instruction cache
    // ===================================================================
    always_comb begin
        if (ctrlUsed[1]) begin
            icPort0.ce   = ctrlPort[1].ce;
            icPort0.we   = ctrlPort[1].we;
            icPort0.addr = ctrlPort[1].addr[9:1];
        end else begin
            icPort0.ce   = fetchEn;
            icPort0.we   = 1'b0;
            icPort0.addr = {fetchAddr[7:0], 1'b1};  // Upper half of the line.
        end
        icPort0.wm = {ctrlPort[1].wm & {4{ctrlPort[1].addr[0]}},
                      ctrlPort[1].wm & {4{~ctrlPort[1].addr[0]}}};
        icPort0.data = {ctrlPort[1].data, ctrlPort[1].data};

        icPort1      = '0;
        icPort1.ce   = fetchEn;
        icPort1.addr = {fetchAddr[7:0], 1'b0};
    end

    always_ff @(posedge clk) begin
        icLaneSel <= ctrlPort[1].addr[0];   // Follows the one-cycle read latency.
    end

    // Console
    always_comb begin
        consoleValid = corePort.ce && corePort.we && corePort.wm == 4'b0001 &&
                       corePort.addr == consoleAddr;
        consoleChar  = corePort.data[7:0];
    end

    assert property (@(posedge clk) ctrlUsed[0] |-> !coreDcWrite)
        else $error("Core wrote the data cache during a burst.");
    assert property (@(posedge clk) ctrlUsed[1] |-> !fetchEn)
        else $error("Core fetched during an instruction cache burst.");

endmodule

//--- rtl/memSubsystem.sv
`timescale 1ns/10ps

module memSubsystem (
    input  logic                clk,
    input  logic                reset,
    input  memPkg::mcCmd_t      cmd,
    output logic                busy,
    output memPkg::progress_t   progress,
    input  memPkg::cachePort_t  corePort,
    input  logic                coreReadEn,
    input  memPkg::wordAddr_t   coreReadAddr,
    output memPkg::word_t       coreReadData,
    input  logic                fetchEn,
    input  memPkg::instrAddr_t  fetchAddr,
    output memPkg::instrLine_t  fetchData,
    output logic                extEn,
    output memPkg::word_t       extOut,
    input  memPkg::word_t       extIn,
    output logic                consoleValid,
    output logic [7:0]          consoleChar
);
    import memPkg::*;

    logic [1:0]       ctrlUsed;
    cachePort_t [1:0] ctrlPort;
    cachePort_t       dcPort;
    logic             dcReadEn;
    sramAddr_t        dcReadAddr;
    word_t            dcRdata;
    icPort_t          icPort0;
    icPort_t          icPort1;
    logic             icLaneSel;
    icEntry_t         icRdataHi;
    icEntry_t         icRdataLo;
    word_t            icacheRdata;

    assign fetchData   = {icRdataHi, icRdataLo};
    assign icacheRdata = icLaneSel ? icRdataHi[63:32] : icRdataHi[31:0];

    memoryController u_memCtrl (
        .clk(clk),
        .reset(reset),
        .cmd(cmd),
        .busy(busy),
        .progress(progress),
        .ctrlUsed(ctrlUsed),
        .ctrlPort(ctrlPort),
        .dcacheRdata(dcRdata),
        .icacheRdata(icacheRdata),
        .extEn(extEn),
        .extOut(extOut),
        .extIn(extIn)
    );

    cachePortRouter u_router (
        .clk(clk),
        .ctrlUsed(ctrlUsed),
        .ctrlPort(ctrlPort),
        .corePort(corePort),
        .coreReadEn(coreReadEn),
        .coreReadAddr(coreReadAddr),
        .fetchEn(fetchEn),
        .fetchAddr(fetchAddr),
        .dcPort(dcPort),
        .dcReadEn(dcReadEn),
        .dcReadAddr(dcReadAddr),
        .icPort0(icPort0),
        .icPort1(icPort1),
        .icLaneSel(icLaneSel),
        .consoleValid(consoleValid),
        .consoleChar(consoleChar)
    );

    cacheSram #(.dataWidth($bits(word_t)), .depth(dcacheWords)) dcache (
        .clk(clk),
        .ce(dcPort.ce),
        .we(dcPort.we),
        .wm(dcPort.wm),
        .addr(dcPort.addr[9:0]),
        .data(dcPort.data),
        .rdata(dcRdata),
        .ce1(dcReadEn),
        .addr1(dcReadAddr),
        .rdata1(coreReadData)
    );

    cacheSram #(.dataWidth($bits(icEntry_t)), .depth(icacheDepth)) icache (
        .clk(clk),
        .ce(icPort0.ce),
        .we(icPort0.we),
        .wm(icPort0.wm),
        .addr(icPort0.addr),
        .data(icPort0.data),
        .rdata(icRdataHi),
        .ce1(icPort1.ce),
        .addr1(icPort1.addr),
        .rdata1(icRdataLo)
    );

endmodule

//--- tests/extMemModel.sv
`timescale 1ns/10ps

module extMemModel (
    input  logic          clk,
    input  logic          reset,
    input  logic          extEn,
    input  memPkg::word_t extOut,
    output memPkg::word_t extIn
);
    import memPkg::*;

    localparam int memWords = 65536;

    word_t       mem [memWords];
    logic        active;
    logic        store;
    logic [15:0] base;
    logic [15:0] count;

    initial begin
        for (int a = 0; a < memWords; a++) begin
            mem[a] = {16'(a), ~16'(a)};     // Upper half is the index, lower half its inverse.
        end
        extIn  = '0;
        active = 1'b0;
    end

    // The first extEn cycle carries the command word, then burstLen data cycles follow.
    always @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            count  <= '0;
            extIn  <= '0;
        end else if (active) begin
            if (store) begin
                mem[base + count] <= extOut;
            end
            extIn <= mem[base + count + 16'd1];     // Load data runs one word ahead.
            if (count == 16'(burstLen - 1)) begin
                active <= 1'b0;
            end
            count <= count + 16'd1;
        end else if (extEn) begin
            active <= 1'b1;
            store  <= extOut[31];
            base   <= extOut[15:0];
            count  <= '0;
            extIn  <= mem[extOut[15:0]];
        end
    end

endmodule

//--- tests/memSubsystemTb.sv
`timescale 1ns/10ps

module memSubsystemTb;
    import memPkg::*;

    typedef struct packed {
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        instrLine_t  line;
    } goldenOp_t;

    logic       clk;
    logic       reset;
    mcCmd_t     cmd;
    logic       busy;
    progress_t  progress;
    cachePort_t corePort;
    logic       coreReadEn;
    wordAddr_t  coreReadAddr;
    word_t      coreReadData;
    logic       fetchEn;
    instrAddr_t fetchAddr;
    instrLine_t fetchData;
    logic       extEn;
    word_t      extOut;
    word_t      extIn;
    logic       consoleValid;
    logic [7:0] consoleChar;

    goldenOp_t ops[$];
    int        opCount = 0;

    memSubsystem u_dut (.*);

    extMemModel u_extMem (
        .clk(clk),
        .reset(reset),
        .extEn(extEn),
        .extOut(extOut),
        .extIn(extIn)
    );

    // ===================================================================
    // Failure handling and compare tasks
    // ===================================================================
    task automatic abortRun(input string reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abortRun("Stopped at the first mismatch.");
        end
    endtask

    task automatic checkLine(input string name, input instrLine_t got, input instrLine_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abortRun("Stopped at the first mismatch.");
        end
    endtask

    task automatic checkChar(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abortRun("Stopped at the first mismatch.");
        end
    endtask

    task automatic checkProgress(input string name, input progress_t got, input progress_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abortRun("Stopped at the first mismatch.");
        end
    endtask

    // ===================================================================
    // Core and controller operations
    // ===================================================================
    task automatic nextCycle();
        @(posedge clk);
        #1;     // Inputs change just after the edge.
    endtask

    task automatic runBurst(input logic toExt, input goldenOp_t g);
        mcCmd_t c;
        c          = '0;
        c.ce       = 1'b1;
        c.we       = toExt;
        c.cacheId  = g.a[0];
        c.sramAddr = g.b[9:0];
        c.extAddr  = g.c[29:0];
        cmd = c;
        nextCycle();
        cmd = '0;
        if (!busy) begin
            abortRun("The controller did not take the burst command.");
        end
        if (g.d[0]) begin
            nextCycle();
            nextCycle();
            c.sramAddr = c.sramAddr + 10'h100;  // A second command that must be dropped.
            c.extAddr  = c.extAddr + 30'h1000;
            cmd = c;
            nextCycle();
            cmd = '0;
        end
        while (busy) begin
            nextCycle();
        end
        checkProgress("progress", progress, g.e[9:0]);
        if (extEn) begin
            abortRun("extEn stayed high after busy fell.");
        end
    endtask

    task automatic coreWrite(input wordAddr_t addr, input byteMask_t mask, input word_t data);
        cachePort_t p;
        p      = '0;
        p.ce   = 1'b1;
        p.we   = 1'b1;
        p.wm   = mask;
        p.addr = addr;
        p.data = data;
        corePort = p;
        nextCycle();
        corePort = '0;
    endtask

    task automatic coreRead(input wordAddr_t addr, input word_t exp);
        coreReadEn   = 1'b1;
        coreReadAddr = addr;
        nextCycle();
        coreReadEn = 1'b0;
        checkWord($sformatf("coreReadData[%h]", addr), coreReadData, exp);
    endtask

    task automatic fetchLine(input instrAddr_t addr, input instrLine_t exp);
        fetchEn   = 1'b1;
        fetchAddr = addr;
        nextCycle();
        fetchEn = 1'b0;
        checkLine($sformatf("fetchData[%h]", addr), fetchData, exp);
    endtask

    task automatic consoleWrite(input logic [7:0] ch, input logic [7:0] exp);
        cachePort_t p;
        p      = '0;
        p.ce   = 1'b1;
        p.we   = 1'b1;
        p.wm   = 4'b0001;
        p.addr = consoleAddr;
        p.data = {24'h0, ch};
        corePort = p;
        #1;
        if (!consoleValid) begin
            abortRun("consoleValid did not rise for a console write.");
        end
        checkChar("consoleChar", consoleChar, exp);
        nextCycle();
        corePort = '0;
        #1;
        if (consoleValid) begin
            abortRun("consoleValid stayed high after the console write.");
        end
        nextCycle();
    endtask

    // ===================================================================
    // Golden file
    // ===================================================================
    task automatic loadGolden();
        int               fd;
        int               n;
        int               want;
        logic [7:0]       opChar;
        logic [8*160-1:0] skipBuf;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        logic [31:0]      d;
        logic [31:0]      e;
        instrLine_t       line;
        goldenOp_t        g;
        fd = $fopen("tests/memGolden.txt", "r");
        if (fd == 0) begin
            abortRun("Cannot open tests/memGolden.txt.");
        end
        while ($fscanf(fd, " %c", opChar) == 1) begin
            a = '0;
            b = '0;
            c = '0;
            d = '0;
            e = '0;
            line = '0;
            n    = 0;
            want = 0;
            case (opChar)
                "#": n = $fgets(skipBuf, fd);  // Column notes.
                "L", "S": begin
                    n    = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
                    want = 5;
                end
                "W": begin
                    n    = $fscanf(fd, "%h %h %h", a, b, c);
                    want = 3;
                end
                "F": begin
                    n    = $fscanf(fd, "%h %h", a, line);
                    want = 2;
                end
                "R", "C", "X": begin
                    n    = $fscanf(fd, "%h %h", a, b);
                    want = 2;
                end
                default: abortRun("Unknown opcode in the golden file.");
            endcase
            if (opChar != "#") begin
                if (n != want) begin
                    abortRun("A line in the golden file has missing or bad fields.");
                end
                g = '{op: opChar, a: a, b: b, c: c, d: d, e: e, line: line};
                ops.push_back(g);
            end
        end
        $fclose(fd);
        if (ops.size() == 0) begin
            abortRun("The golden file holds no operations.");
        end
        opCount = ops.size();
    endtask

    task automatic runOp(input goldenOp_t g);
        case (g.op)
            "L": runBurst(1'b0, g);
            "S": runBurst(1'b1, g);
            "W": coreWrite(g.a[29:0], g.b[3:0], g.c);
            "R": coreRead(g.a[29:0], g.b);
            "F": fetchLine(g.a[27:0], g.line);
            "C": consoleWrite(g.a[7:0], g.b[7:0]);
            "X": checkWord($sformatf("extMem[%h]", g.a[15:0]), u_extMem.mem[g.a[15:0]], g.b);
            default: abortRun("Unknown opcode in the operation list.");
        endcase
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        wait (opCount > 0);
        repeat (opCount * (burstLen + 10)) @(posedge clk);
        abortRun("The watchdog expired before all golden operations finished.");
    end

    initial begin
        reset        = 1'b1;
        cmd          = '0;
        corePort     = '0;
        coreReadEn   = 1'b0;
        coreReadAddr = '0;
        fetchEn      = 1'b0;
        fetchAddr    = '0;
        loadGolden();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        if (busy || extEn || consoleValid) begin
            abortRun("busy, extEn or consoleValid is high after reset.");
        end
        foreach (ops[i]) begin
            runOp(ops[i]);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- tests/memGolden.txt
# L/S cacheId sramAddr extAddr decoy progress; W addr mask data; R addr word
# F line expectedLine; C char expectedChar; X extAddr word (all fields hex)
L 0 000 00000100 0 10
R 000 0100FEFF
R 005 0105FEFA
W 005 3 0000ABCD
R 005 0105ABCD
W 006 C 12340000
R 006 1234FEF9
W 407 F DEADBEEF
R 007 0107FEF8
S 0 000 00002000 0 10
X 2000 0100FEFF
X 2005 0105ABCD
X 2006 1234FEF9
X 2007 0107FEF8
L 1 010 00000300 0 10
F 04 0303FCFC0302FCFD0301FCFE0300FCFF
F 07 030FFCF0030EFCF1030DFCF2030CFCF3
C 4F 4F
C 4B 4B
R 000 0100FEFF
W 120 F 55AA55AA
L 0 020 00000500 1 10
R 020 0500FAFF
R 02F 050FFAF0
R 120 55AA55AA

//--- project.f
rtl/memPkg.sv
rtl/cacheSram.sv
rtl/memoryController.sv
rtl/cachePortRouter.sv
rtl/memSubsystem.sv
tests/extMemModel.sv
tests/memSubsystemTb.sv

//--- Makefile
TOP = memSubsystemTb
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
